// ==== noc_loaded.f ====
logic/noc_pkg.sv
logic/ring_router.sv
logic/pe_wrapper.sv
logic/master_module.sv
logic/noc_loaded.sv
sim/tb_noc_loaded.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_noc_loaded \
    -f noc_loaded.f -o tb_noc_loaded
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_noc_loaded > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation PASSED"

// ==== sim/tb_noc_loaded.sv ====
`timescale 1ns/1ps

module tb_noc_loaded import noc_pkg::*; ();

    localparam int SCALE_SHIFT     = 1;
    localparam int MAX_OUTSTANDING = 4;
    localparam int NUM_ROWS        = 24;
    localparam int HOLD_FIRST      = 16;
    localparam int TIMEOUT_CYCLES  = NUM_ROWS * 200;

    logic clk = 1'b0;
    logic rst;
    logic req_valid;
    req_t req;
    logic req_ready;
    logic rsp_valid;
    rsp_t rsp;
    logic rsp_ready;

    req_t rows [NUM_ROWS];
    rsp_t exp_table [256];
    logic known [256];
    logic seen [256];
    int   received_count = 0;
    int   hold_accepted  = 0;
    int   cycle_count    = 0;
    // Result port is always ready, randomly stalled or held low
    int   ready_mode     = 0;
    logic hold_phase     = 1'b0;

    noc_loaded #(
        .SCALE_SHIFT(SCALE_SHIFT),
        .PE_STAGES(2),
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) dut_i (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic req_t make_row(input logic [NODEW-1:0] dest, input op_e op,
                                      input logic [TAGW-1:0] tag, input lanes_t payload);
        return '{dest: dest, op: op, tag: tag, payload: payload};
    endfunction

    // Reference model of the PE ops and the master's destination check
    function automatic rsp_t expected_result(input req_t r);
        rsp_t e;
        int   v;
        int   acc;
        e = '{src: r.dest, err: 1'b0, tag: r.tag, payload: '0};
        acc = 0;
        if (r.dest == 3'd0 || r.dest > 3'd4) begin
            e.err = 1'b1;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                v = int'($signed(r.payload[i]));
                case (r.op)
                    op_pass:  e.payload[i] = r.payload[i];
                    op_relu:  e.payload[i] = (v < 0) ? 16'd0 : r.payload[i];
                    op_scale: e.payload[i] = 16'(v * (2 ** SCALE_SHIFT));
                    op_sum:   acc = acc + v;
                endcase
            end
            if (r.op == op_sum) begin
                e.payload[0] = 16'(acc);
            end
        end
        return e;
    endfunction

    task automatic check_response(input rsp_t got);
        rsp_t exp;
        assert (known[got.tag])
            else fail_run($sformatf("Result arrived with unknown tag %0d", got.tag));
        assert (!seen[got.tag])
            else fail_run($sformatf("Tag %0d returned more than once", got.tag));
        exp = exp_table[got.tag];
        assert (got.err == exp.err)
            else fail_run($sformatf("CHECK FAILED t=%0t rsp.err (tag %0d): expected %0b, got %0b",
                                    $time, got.tag, exp.err, got.err));
        assert (got.src == exp.src)
            else fail_run($sformatf("CHECK FAILED t=%0t rsp.src (tag %0d): expected %0d, got %0d",
                                    $time, got.tag, exp.src, got.src));
        if (!exp.err) begin
            assert (got.payload == exp.payload)
                else fail_run($sformatf(
                    "CHECK FAILED t=%0t rsp.payload (tag %0d): expected %h, got %h",
                    $time, got.tag, exp.payload, got.payload));
        end
        seen[got.tag] = 1'b1;
        received_count = received_count + 1;
    endtask

    task automatic send_request(input req_t r);
        logic taken;
        req = r;
        req_valid = 1'b1;
        do begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end while (!taken);
        req_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(12794));
        rsp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (ready_mode == 1) begin
                rsp_ready = ($urandom % 4) != 0;
            end else begin
                rsp_ready = (ready_mode == 0);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < TIMEOUT_CYCLES)
            else fail_run($sformatf("Timeout after %0d cycles without completing",
                                    TIMEOUT_CYCLES));
    end

    // Handshakes are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && rsp_valid && rsp_ready) begin
            check_response(rsp);
        end
        if (!rst && hold_phase && !rsp_ready && req_valid && req_ready) begin
            hold_accepted = hold_accepted + 1;
            assert (hold_accepted <= MAX_OUTSTANDING)
                else fail_run($sformatf(
                    "CHECK FAILED t=%0t req_ready: expected at most %0d accepts, got %0d",
                    $time, MAX_OUTSTANDING, hold_accepted));
        end
    end

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        for (int t = 0; t < 256; t++) begin
            known[t] = 1'b0;
            seen[t] = 1'b0;
        end
        rows[0]  = make_row(3'd1, op_pass,  8'h41, 64'h0004_FFFD_0002_0001);
        rows[1]  = make_row(3'd2, op_relu,  8'h42, 64'h8000_0005_FFFF_7FFF);
        rows[2]  = make_row(3'd3, op_scale, 8'h43, 64'h4000_C000_0001_7FFF);
        rows[3]  = make_row(3'd4, op_sum,   8'h44, 64'h7FFF_7FFF_0001_0002);
        rows[4]  = make_row(3'd2, op_pass,  8'h45, 64'hFFFF_FFFF_FFFF_FFFF);
        rows[5]  = make_row(3'd3, op_relu,  8'h46, 64'h0010_FFF0_0020_FFE0);
        rows[6]  = make_row(3'd4, op_scale, 8'h47, 64'h8000_FFFF_3FFF_0003);
        rows[7]  = make_row(3'd1, op_sum,   8'h48, 64'h8000_8000_0001_FFFF);
        rows[8]  = make_row(3'd0, op_pass,  8'h49, 64'h1234_5678_9ABC_DEF0);
        rows[9]  = make_row(3'd3, op_pass,  8'h4A, 64'h7FFF_8000_0000_0001);
        rows[10] = make_row(3'd4, op_relu,  8'h4B, 64'h0001_8001_7FFF_FFFE);
        rows[11] = make_row(3'd1, op_scale, 8'h4C, 64'hE000_2000_FFFE_0100);
        rows[12] = make_row(3'd2, op_sum,   8'h4D, 64'h0003_0002_FFFF_FFFB);
        rows[13] = make_row(3'd6, op_relu,  8'h4E, 64'h0001_0002_0003_0004);
        rows[14] = make_row(3'd4, op_pass,  8'h4F, 64'hA5A5_5A5A_0F0F_F0F0);
        rows[15] = make_row(3'd1, op_relu,  8'h50, 64'h8001_0000_7FFE_FF00);
        rows[16] = make_row(3'd2, op_scale, 8'h51, 64'h7FFF_FF80_0040_8001);
        rows[17] = make_row(3'd3, op_sum,   8'h52, 64'h8000_8000_8000_8000);
        rows[18] = make_row(3'd1, op_pass,  8'h53, 64'h0BAD_F00D_CAFE_0001);
        rows[19] = make_row(3'd2, op_relu,  8'h54, 64'hFFFF_0001_FFFE_0002);
        rows[20] = make_row(3'd3, op_scale, 8'h55, 64'h0101_FEFE_4001_BFFF);
        rows[21] = make_row(3'd4, op_sum,   8'h56, 64'h0064_FF9C_00C8_FF38);
        rows[22] = make_row(3'd0, op_sum,   8'h57, 64'hFFFF_0000_FFFF_0000);
        rows[23] = make_row(3'd4, op_scale, 8'h58, 64'h2000_E000_7000_9000);
        for (int i = 0; i < NUM_ROWS; i++) begin
            exp_table[rows[i].tag] = expected_result(rows[i]);
            known[rows[i].tag] = 1'b1;
        end

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!rsp_valid)
            else fail_run($sformatf("CHECK FAILED t=%0t rsp_valid: expected 0, got %b",
                                    $time, rsp_valid));
        assert (req_ready)
            else fail_run($sformatf("CHECK FAILED t=%0t req_ready: expected 1, got %b",
                                    $time, req_ready));

        // Free-running part with random result stalls
        @(posedge clk);
        ready_mode = 1;
        #1;
        for (int i = 0; i < HOLD_FIRST; i++) begin
            send_request(rows[i]);
        end
        @(posedge clk);
        while (received_count < HOLD_FIRST) begin
            @(posedge clk);
        end

        // Results held back, acceptance must stop at the limit
        ready_mode = 2;
        hold_phase = 1'b1;
        #1;
        fork
            for (int i = HOLD_FIRST; i < NUM_ROWS; i++) begin
                send_request(rows[i]);
            end
            begin
                repeat (60) @(posedge clk);
                assert (hold_accepted > 0)
                    else fail_run("No request was accepted while results were held back");
                hold_phase = 1'b0;
                ready_mode = 1;
            end
        join

        while (received_count < NUM_ROWS) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            assert (seen[rows[i].tag])
                else fail_run($sformatf("Tag %0d never returned", rows[i].tag));
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== logic/noc_loaded.sv ====
`timescale 1ns/1ps

module noc_loaded import noc_pkg::*; #(
    parameter int SCALE_SHIFT     = 1,
    parameter int PE_STAGES       = 2,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic clk,
    input  logic rst,

    input  logic req_valid,
    input  req_t req,
    output logic req_ready,

    output logic rsp_valid,
    output rsp_t rsp,
    input  logic rsp_ready
);

    // ring_* index n is router n's ring output
    logic [NODES-1:0] ring_valid;
    logic [NODES-1:0] ring_ready;
    flit_t            ring_flit [NODES];

    // inj_* feed router local inputs, ej_* leave router local outputs
    logic [NODES-1:0] inj_valid;
    logic [NODES-1:0] inj_ready;
    flit_t            inj_flit [NODES];
    logic [NODES-1:0] ej_valid;
    logic [NODES-1:0] ej_ready;
    flit_t            ej_flit [NODES];

    master_module #(
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) master_inst (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready),
        .tx_valid(inj_valid[0]), .tx_flit(inj_flit[0]), .tx_ready(inj_ready[0]),
        .rx_valid(ej_valid[0]), .rx_flit(ej_flit[0]), .rx_ready(ej_ready[0])
    );

    for (genvar n = 0; n < NODES; n++) begin : g_router
        localparam int PREV = (n + NODES - 1) % NODES;

        ring_router #(
            .NODE_ID(n)
        ) router_inst (
            .clk(clk), .rst(rst),
            .ring_in_valid(ring_valid[PREV]), .ring_in_flit(ring_flit[PREV]),
            .ring_in_ready(ring_ready[PREV]),
            .local_in_valid(inj_valid[n]), .local_in_flit(inj_flit[n]),
            .local_in_ready(inj_ready[n]),
            .ring_out_valid(ring_valid[n]), .ring_out_flit(ring_flit[n]),
            .ring_out_ready(ring_ready[n]),
            .local_out_valid(ej_valid[n]), .local_out_flit(ej_flit[n]),
            .local_out_ready(ej_ready[n])
        );
    end

    for (genvar p = 1; p < NODES; p++) begin : g_pe
        pe_wrapper #(
            .SCALE_SHIFT(SCALE_SHIFT),
            .PE_STAGES(PE_STAGES)
        ) pe_inst (
            .clk(clk), .rst(rst),
            .in_valid(ej_valid[p]), .in_flit(ej_flit[p]), .in_ready(ej_ready[p]),
            .out_valid(inj_valid[p]), .out_flit(inj_flit[p]), .out_ready(inj_ready[p])
        );
    end

endmodule

// ==== logic/master_module.sv ====
`timescale 1ns/1ps

module master_module import noc_pkg::*; #(
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  req_valid,
    input  req_t  req,
    output logic  req_ready,

    output logic  rsp_valid,
    output rsp_t  rsp,
    input  logic  rsp_ready,

    output logic  tx_valid,
    output flit_t tx_flit,
    input  logic  tx_ready,

    input  logic  rx_valid,
    input  flit_t rx_flit,
    output logic  rx_ready
);

    localparam int CNTW = $clog2(MAX_OUTSTANDING + 1);

    logic [CNTW-1:0] count;
    logic            tx_free;
    logic            rsp_free;
    logic            req_take;
    logic            bad_dest;
    logic            reject;
    logic            send;
    logic            rx_take;
    logic            rsp_take;

    assign tx_free  = !tx_valid || tx_ready;
    assign rsp_free = !rsp_valid || rsp_ready;
    assign req_ready = (count < CNTW'(MAX_OUTSTANDING)) && tx_free && rsp_free;

    assign req_take = req_valid && req_ready;
    assign bad_dest = (req.dest == '0) || (req.dest >= NODEW'(NODES));
    assign reject   = req_take && bad_dest;
    assign send     = req_take && !bad_dest;

    // Rejected request takes the result slot, ring waits
    assign rx_ready = rsp_free && !reject;
    assign rx_take  = rx_valid && rx_ready;
    assign rsp_take = rsp_valid && rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            tx_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            if (req_take && !rsp_take) begin
                count <= count + 1'b1;
            end else if (!req_take && rsp_take) begin
                count <= count - 1'b1;
            end
            if (send) begin
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end
            if (reject || rx_take) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            tx_flit <= '{dest: req.dest, src: '0, op: req.op, err: 1'b0,
                         tag: req.tag, payload: req.payload};
        end
        if (reject) begin
            rsp <= '{src: req.dest, err: 1'b1, tag: req.tag, payload: '0};
        end else if (rx_take) begin
            rsp <= '{src: rx_flit.src, err: rx_flit.err, tag: rx_flit.tag,
                     payload: rx_flit.payload};
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= CNTW'(MAX_OUTSTANDING));

endmodule

// ==== logic/pe_wrapper.sv ====
`timescale 1ns/1ps

module pe_wrapper import noc_pkg::*; #(
    parameter int SCALE_SHIFT = 1,
    parameter int PE_STAGES   = 2
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  in_valid,
    input  flit_t in_flit,
    output logic  in_ready,

    output logic  out_valid,
    output flit_t out_flit,
    input  logic  out_ready
);

    logic [PE_STAGES-1:0] stg_valid;
    flit_t                stg_flit [PE_STAGES];
    lanes_t               res;
    flit_t                head;
    logic                 advance;

    // Whole pipeline freezes on a stalled output
    assign advance  = !(out_valid && !out_ready);
    assign in_ready = advance;

    always_comb begin
        res = in_flit.payload;
        case (in_flit.op)
            op_pass: res = in_flit.payload;
            op_relu: begin
                for (int i = 0; i < LANES; i++) begin
                    if (in_flit.payload[i][LANEW-1]) begin
                        res[i] = '0;
                    end
                end
            end
            op_scale: begin
                for (int i = 0; i < LANES; i++) begin
                    res[i] = in_flit.payload[i] << SCALE_SHIFT;
                end
            end
            op_sum: begin
                res = '0;
                for (int i = 0; i < LANES; i++) begin
                    res[0] = res[0] + in_flit.payload[i];
                end
            end
        endcase
    end

    // Result heads back to the master
    always_comb begin
        head         = in_flit;
        head.dest    = '0;
        head.src     = in_flit.dest;
        head.payload = res;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stg_valid <= '0;
        end else if (advance) begin
            stg_valid[0] <= in_valid;
            for (int s = 1; s < PE_STAGES; s++) begin
                stg_valid[s] <= stg_valid[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            stg_flit[0] <= head;
            for (int s = 1; s < PE_STAGES; s++) begin
                stg_flit[s] <= stg_flit[s-1];
            end
        end
    end

    assign out_valid = stg_valid[PE_STAGES-1];
    assign out_flit  = stg_flit[PE_STAGES-1];

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

// ==== logic/ring_router.sv ====
`timescale 1ns/1ps

module ring_router import noc_pkg::*; #(
    parameter int NODE_ID = 0
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  ring_in_valid,
    input  flit_t ring_in_flit,
    output logic  ring_in_ready,

    input  logic  local_in_valid,
    input  flit_t local_in_flit,
    output logic  local_in_ready,

    output logic  ring_out_valid,
    output flit_t ring_out_flit,
    input  logic  ring_out_ready,

    output logic  local_out_valid,
    output flit_t local_out_flit,
    input  logic  local_out_ready
);

    logic ring_to_local;
    logic loc_to_local;
    logic ro_free;
    logic lo_free;
    logic ring_go;
    logic local_go;
    logic ro_load;
    logic lo_load;
    logic ro_from_ring;
    logic lo_from_ring;

    assign ring_to_local = (ring_in_flit.dest == NODEW'(NODE_ID));
    assign loc_to_local  = (local_in_flit.dest == NODEW'(NODE_ID));

    // Free only when empty, so ready never loops around the ring
    assign ro_free = !ring_out_valid;
    assign lo_free = !local_out_valid;

    assign ring_in_ready = ring_to_local ? lo_free : ro_free;
    assign ring_go       = ring_in_valid && ring_in_ready;

    // Injection yields to ring traffic aiming at the same output
    assign local_in_ready = (loc_to_local ? lo_free : ro_free) &&
                            !(ring_in_valid && (ring_to_local == loc_to_local));
    assign local_go       = local_in_valid && local_in_ready;

    assign ro_from_ring = ring_go && !ring_to_local;
    assign lo_from_ring = ring_go && ring_to_local;
    assign ro_load      = ro_from_ring || (local_go && !loc_to_local);
    assign lo_load      = lo_from_ring || (local_go && loc_to_local);

    always_ff @(posedge clk) begin
        if (rst) begin
            ring_out_valid  <= 1'b0;
            local_out_valid <= 1'b0;
        end else begin
            if (ro_load) begin
                ring_out_valid <= 1'b1;
            end else if (ring_out_ready) begin
                ring_out_valid <= 1'b0;
            end
            if (lo_load) begin
                local_out_valid <= 1'b1;
            end else if (local_out_ready) begin
                local_out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ro_load) begin
            ring_out_flit <= ro_from_ring ? ring_in_flit : local_in_flit;
        end
        if (lo_load) begin
            local_out_flit <= lo_from_ring ? ring_in_flit : local_in_flit;
        end
    end

    a_ring_hold: assert property (@(posedge clk) disable iff (rst)
        ring_out_valid && !ring_out_ready |=> ring_out_valid && $stable(ring_out_flit));

    a_local_hold: assert property (@(posedge clk) disable iff (rst)
        local_out_valid && !local_out_ready |=> local_out_valid && $stable(local_out_flit));

    // Ejected flits must really belong here
    a_local_dest: assert property (@(posedge clk) disable iff (rst)
        lo_load |=> local_out_valid && local_out_flit.dest == NODEW'(NODE_ID));

endmodule

// ==== logic/noc_pkg.sv ====
package noc_pkg;

    // Ring size and field widths
    localparam int NODES = 5;
    localparam int NODEW = 3;
    localparam int LANES = 4;
    localparam int LANEW = 16;
    localparam int TAGW  = 8;

    typedef enum logic [1:0] {
        op_pass  = 2'd0,
        op_relu  = 2'd1,
        op_scale = 2'd2,
        op_sum   = 2'd3
    } op_e;

    // Lane 0 sits in the low bits
    typedef logic [LANES-1:0][LANEW-1:0] lanes_t;

    typedef struct packed {
        logic [NODEW-1:0] dest;
        logic [NODEW-1:0] src;
        op_e              op;
        logic             err;
        logic [TAGW-1:0]  tag;
        lanes_t           payload;
    } flit_t;

    typedef struct packed {
        logic [NODEW-1:0] dest;
        op_e              op;
        logic [TAGW-1:0]  tag;
        lanes_t           payload;
    } req_t;

    typedef struct packed {
        logic [NODEW-1:0] src;
        logic             err;
        logic [TAGW-1:0]  tag;
        lanes_t           payload;
    } rsp_t;

endpackage
